// File: Makefile
# Verilator build and run of the coding quadtree testbench

VERILATOR ?= verilator
TOP       ?= cqt_tb
DUT_TOP   ?= cqt_decoder
FLIST     ?= tb.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= Simulation finished: PASS

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_STR)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD)

// File: bench/cqt_assert.sv
// protocol checks on the coding quadtree decoder outputs
`timescale 1ns/1ps

module cqt_assert (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      dec_run,
    input logic                      ctx_addr_vld,
    input logic                      cu_start,
    input logic [2:0]                cu_log2_size,
    input logic                      cqt_done
);

run_vld_equal: assert property (@(posedge clk) disable iff (!rst_n)
    dec_run == ctx_addr_vld)
    else $error("dec_run and ctx_addr_vld differ");

no_cu_with_run: assert property (@(posedge clk) disable iff (!rst_n)
    !(cu_start && dec_run))
    else $error("cu_start and dec_run high together");

cu_size_range: assert property (@(posedge clk) disable iff (!rst_n)
    cu_start |-> (cu_log2_size >= 3'd3 && cu_log2_size <= 3'd6))
    else $error("cu_log2_size out of range");

quiet_in_reset: assert property (@(posedge clk)
    !rst_n |=> !(dec_run || ctx_addr_vld || cu_start || cqt_done))
    else $error("pulse output high after reset edge");

endmodule

bind cqt_decoder cqt_assert i_cqt_assert (
    .clk, .rst_n, .dec_run, .ctx_addr_vld, .cu_start, .cu_log2_size, .cqt_done
);

// File: bench/cqt_tb_model.svh
// reference model of the coding quadtree walk
// tracks a picture-wide depth map at 8x8 granularity and the expected sequences
`ifndef CQT_TB_MODEL_SVH
`define CQT_TB_MODEL_SVH

int pic_depth [64][64];  // [unit row][unit col]
int exp_req[$];
int exp_leaf_x[$];
int exp_leaf_y[$];
int exp_leaf_log2[$];
bit bin_q[$];            // bins handed to the dut, in request order

function automatic void clear_depth_map();
    for (int r = 0; r < 64; r++)
        for (int c = 0; c < 64; c++)
            pic_depth[r][c] = 0;
endfunction

function automatic bit next_bin(input int mode);
    if (mode == 0) return 1'b0;
    if (mode == 1) return 1'b1;
    return bit'($random(seed) & 1);
endfunction

function automatic int split_ctx(input int x, input int y, input int depth);
    int cnt;
    cqt_syntax_pkg::split_ctx_t inc;
    cnt = 0;
    if (x > 0 && pic_depth[y / 8][x / 8 - 1] > depth) cnt++;
    if (y > 0 && pic_depth[y / 8 - 1][x / 8] > depth) cnt++;
    inc = cqt_syntax_pkg::split_ctx_t'(cnt);
    return 2 + int'(inc);  // split_cu_flag ctx 0 sits at 2
endfunction

function automatic void add_leaf(input int x, input int y, input int log2);
    int units;
    units = (1 << log2) / 8;
    exp_leaf_x.push_back(x);
    exp_leaf_y.push_back(y);
    exp_leaf_log2.push_back(log2);
    for (int r = 0; r < units; r++)
        for (int c = 0; c < units; c++)
            pic_depth[y / 8 + r][x / 8 + c] = 6 - log2;
endfunction

// depth-first walk with an explicit stack gives z-order
function automatic void model_ctb(input int cx, input int cy, input int pw, input int ph,
                                  input int mode);
    int sx[$];
    int sy[$];
    int sl[$];
    int x, y, l, half;
    bit split;
    exp_req.delete();
    exp_leaf_x.delete();
    exp_leaf_y.delete();
    exp_leaf_log2.delete();
    bin_q.delete();
    sx.push_back(cx * 64);
    sy.push_back(cy * 64);
    sl.push_back(6);
    while (sx.size() > 0) begin
        x = sx.pop_back();
        y = sy.pop_back();
        l = sl.pop_back();
        split = 1'b0;
        if (x >= pw || y >= ph) continue;  // outside, nothing happens
        if (l == 3) add_leaf(x, y, l);
        else if (x + (1 << l) > pw || y + (1 << l) > ph) split = 1'b1;
        else begin
            exp_req.push_back(split_ctx(x, y, 6 - l));
            split = next_bin(mode);
            bin_q.push_back(split);
            if (!split) add_leaf(x, y, l);
        end
        if (split) begin
            half = 1 << (l - 1);
            for (int k = 3; k >= 0; k--) begin
                sx.push_back(x + (k % 2) * half);
                sy.push_back(y + (k / 2) * half);
                sl.push_back(l - 1);
            end
        end
    end
endfunction

`endif

// File: bench/cqt_tb.sv
// testbench of the coding quadtree decoder
// directed tests against a reference walk with bin and cu partners
`timescale 1ns/1ps
`include "cqt_defines.svh"

module cqt_tb;

localparam int NUM_CTBS = 22;
localparam int TIMEOUT  = 400 * NUM_CTBS;

logic clk, rst_n, cqt_start, bin, bin_vld, cu_done;
logic [`CQT_CTB_X_W-1:0] ctb_x;
logic [`CQT_CTB_Y_W-1:0] ctb_y;
logic [`CQT_PIC_W_W-1:0] pic_width, cu_x;
logic [`CQT_PIC_H_W-1:0] pic_height, cu_y;
logic dec_run, ctx_addr_vld, cu_start, cqt_done;
logic [`CQT_CTX_ADDR_W-1:0] ctx_addr;
logic [2:0] cu_log2_size;

int seed = 32'hfd22;
int cycle_cnt = 0;
int got_reqs, got_leaves, first_addr, first_x, first_y, first_log2;

`include "cqt_tb_model.svh"

cqt_decoder i_cqt_decoder (.*);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
endtask

task automatic check_value(input string name, input int got, input int exp);
    if (got != exp)
        stop_with_failure($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                    $time, name, got, exp));
endtask

always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT)
        stop_with_failure($sformatf("timeout after %0d cycles", cycle_cnt));
end

task automatic set_picture(input int w, input int h);
    pic_width  = `CQT_PIC_W_W'(w);
    pic_height = `CQT_PIC_H_W'(h);
    clear_depth_map();
endtask

// decode one ctb, answering bin requests and cus, checking against the model
task automatic run_ctb(input int cx, input int cy, input int mode);
    int bin_wait, cu_wait, size;
    bit done;
    model_ctb(cx, cy, int'(pic_width), int'(pic_height), mode);
    got_reqs = 0;
    got_leaves = 0;
    first_addr = -1;
    bin_wait = 0;
    cu_wait = 0;
    done = 1'b0;
    @(negedge clk);
    ctb_x = `CQT_CTB_X_W'(cx);
    ctb_y = `CQT_CTB_Y_W'(cy);
    cqt_start = 1'b1;
    @(negedge clk);
    cqt_start = 1'b0;
    while (!done) begin
        bin_vld = 1'b0;
        cu_done = 1'b0;
        if (bin_wait > 0) begin
            bin_wait--;
            if (bin_wait == 0) begin
                bin = bin_q.pop_front();
                bin_vld = 1'b1;
            end
        end
        if (cu_wait > 0) begin
            cu_wait--;
            if (cu_wait == 0) cu_done = 1'b1;
        end
        if (dec_run) begin
            if (exp_req.size() == 0) stop_with_failure("bin request the model does not expect");
            if (got_reqs == 0) first_addr = int'(ctx_addr);
            check_value("ctx_addr", int'(ctx_addr), exp_req.pop_front());
            got_reqs++;
            bin_wait = 1 + ($unsigned($random(seed)) % 3);
        end
        if (cu_start) begin
            if (exp_leaf_x.size() == 0) stop_with_failure("leaf cu the model does not expect");
            if (got_leaves == 0) begin
                first_x = int'(cu_x);
                first_y = int'(cu_y);
                first_log2 = int'(cu_log2_size);
            end
            check_value("cu_x", int'(cu_x), exp_leaf_x.pop_front());
            check_value("cu_y", int'(cu_y), exp_leaf_y.pop_front());
            check_value("cu_log2_size", int'(cu_log2_size), exp_leaf_log2.pop_front());
            size = 1 << cu_log2_size;
            check_value("cu inside picture", int'(cu_x) + size <= int'(pic_width) &&
                        int'(cu_y) + size <= int'(pic_height), 1);
            got_leaves++;
            cu_wait = 2;
        end
        if (cqt_done) begin
            done = 1'b1;
            check_value("requests left at cqt_done", exp_req.size(), 0);
            check_value("leaves left at cqt_done", exp_leaf_x.size(), 0);
        end else
            @(negedge clk);
    end
endtask

task automatic test_root_leaf();
    set_picture(128, 128);
    run_ctb(0, 0, 0);
    check_value("request count", got_reqs, 1);
    check_value("leaf count", got_leaves, 1);
    check_value("root ctx_addr", first_addr, 2);
    check_value("leaf x", first_x, 0);
    check_value("leaf y", first_y, 0);
    check_value("leaf log2 size", first_log2, 6);
endtask

task automatic test_full_split();
    set_picture(256, 256);
    run_ctb(0, 0, 1);
    check_value("request count", got_reqs, 21);
    check_value("leaf count", got_leaves, 64);
endtask

task automatic test_picture_edge();
    set_picture(200, 136);
    for (int cy = 0; cy < 3; cy++)
        for (int cx = 0; cx < 4; cx++)
            run_ctb(cx, cy, 2);
endtask

task automatic test_context_select();
    set_picture(128, 64);
    run_ctb(0, 0, 1);
    check_value("first ctb root ctx_addr", first_addr, 2);
    run_ctb(1, 0, 2);
    check_value("second ctb root ctx_addr", first_addr, 3);  // left is fully split
endtask

task automatic test_raster_random();
    set_picture(128, 128);
    for (int cy = 0; cy < 2; cy++)
        for (int cx = 0; cx < 2; cx++)
            run_ctb(cx, cy, 2);
endtask

task automatic test_mid_reset();
    set_picture(64, 64);
    @(negedge clk);
    ctb_x = '0;
    ctb_y = '0;
    cqt_start = 1'b1;
    @(negedge clk);
    cqt_start = 1'b0;
    repeat (6) @(negedge clk);  // root request left unanswered
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    bin = 1'b0;
    bin_vld = 1'b1;  // late answer to the aborted request
    repeat (5) begin
        @(negedge clk);
        bin_vld = 1'b0;
        check_value("dec_run after reset", int'(dec_run), 0);
        check_value("ctx_addr_vld after reset", int'(ctx_addr_vld), 0);
        check_value("cu_start after reset", int'(cu_start), 0);
        check_value("cqt_done after reset", int'(cqt_done), 0);
    end
    run_ctb(0, 0, 2);
endtask

initial begin
    rst_n = 1'b0;
    cqt_start = 1'b0;
    bin = 1'b0;
    bin_vld = 1'b0;
    cu_done = 1'b0;
    ctb_x = '0;
    ctb_y = '0;
    pic_width = '0;
    pic_height = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    test_root_leaf();
    test_full_split();
    test_picture_edge();
    test_context_select();
    test_raster_random();
    test_mid_reset();
    repeat (2) @(negedge clk);
    $display("Simulation finished: PASS");
    $finish;
end

endmodule

// File: hdl/cqt_ctx_select.sv
// split_cu_flag context selection
// compares neighbour depths and issues the registered bin request
`timescale 1ns/1ps
`include "cqt_defines.svh"

module cqt_ctx_select (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [`CQT_PIC_W_W-1:0]                     node_x,
    input  logic [`CQT_PIC_H_W-1:0]                     node_y,
    input  cqt_syntax_pkg::cqt_depth_t                  node_depth,
    input  logic                                        flag_req,
    input  cqt_syntax_pkg::cqt_depth_t                  left_depth,
    input  cqt_syntax_pkg::cqt_depth_t                  above_depth,
    output logic [`CQT_LOG2_CTB-`CQT_LOG2_MIN_CU-1:0]   unit_col,
    output logic [`CQT_LOG2_CTB-`CQT_LOG2_MIN_CU-1:0]   unit_row,
    output logic                                        dec_run,
    output logic                                        ctx_addr_vld,
    output logic [`CQT_CTX_ADDR_W-1:0]                  ctx_addr
);

logic                       avail_l;
logic                       avail_a;
logic                       cond_l;
logic                       cond_a;
cqt_syntax_pkg::split_ctx_t ctx_inc;

// 8x8 unit inside the ctb
assign unit_col = node_x[`CQT_LOG2_CTB-1:`CQT_LOG2_MIN_CU];
assign unit_row = node_y[`CQT_LOG2_CTB-1:`CQT_LOG2_MIN_CU];

// neighbours exist unless the node sits on the picture edge
assign avail_l = (node_x != '0);
assign avail_a = (node_y != '0);

assign cond_l = avail_l && (left_depth > node_depth);
assign cond_a = avail_a && (above_depth > node_depth);

always_comb begin
    case ({cond_l, cond_a})
        2'b00:   ctx_inc = cqt_syntax_pkg::CTX_NONE;
        2'b11:   ctx_inc = cqt_syntax_pkg::CTX_BOTH;
        default: ctx_inc = cqt_syntax_pkg::CTX_ONE;
    endcase
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        dec_run      <= 1'b0;
        ctx_addr_vld <= 1'b0;
    end else begin
        dec_run      <= flag_req;
        ctx_addr_vld <= flag_req;
    end
end

always_ff @(posedge clk) begin
    if (flag_req)
        ctx_addr <= `CQT_CTX_SPLIT_BASE + {{(`CQT_CTX_ADDR_W-2){1'b0}}, ctx_inc};
end

endmodule

// File: hdl/cqt_decoder.sv
// coding quadtree stage of the cabac decoder
// walker, split context selection and depth map for one ctb at a time
`timescale 1ns/1ps
`include "cqt_defines.svh"

module cqt_decoder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cqt_start,
    input  logic [`CQT_CTB_X_W-1:0]     ctb_x,
    input  logic [`CQT_CTB_Y_W-1:0]     ctb_y,
    input  logic [`CQT_PIC_W_W-1:0]     pic_width,
    input  logic [`CQT_PIC_H_W-1:0]     pic_height,
    input  logic                        bin,
    input  logic                        bin_vld,
    input  logic                        cu_done,
    output logic                        dec_run,
    output logic                        ctx_addr_vld,
    output logic [`CQT_CTX_ADDR_W-1:0]  ctx_addr,
    output logic                        cu_start,
    output logic [`CQT_PIC_W_W-1:0]     cu_x,
    output logic [`CQT_PIC_H_W-1:0]     cu_y,
    output logic [2:0]                  cu_log2_size,
    output logic                        cqt_done
);

localparam int UW = `CQT_LOG2_CTB - `CQT_LOG2_MIN_CU;

logic [`CQT_PIC_W_W-1:0]    node_x;
logic [`CQT_PIC_H_W-1:0]    node_y;
cqt_syntax_pkg::cqt_depth_t node_depth;
logic                       flag_req;
logic [UW-1:0]              unit_col;
logic [UW-1:0]              unit_row;
cqt_syntax_pkg::cqt_depth_t left_depth;
cqt_syntax_pkg::cqt_depth_t above_depth;

cqt_walker i_cqt_walker (
    .clk, .rst_n,
    .cqt_start, .ctb_x, .ctb_y, .pic_width, .pic_height,
    .bin, .bin_vld, .cu_done,
    .node_x, .node_y, .node_depth,
    .flag_req,
    .cu_start, .cu_x, .cu_y, .cu_log2_size,
    .cqt_done
);

cqt_ctx_select i_cqt_ctx_select (
    .clk, .rst_n,
    .node_x, .node_y, .node_depth,
    .flag_req,
    .left_depth, .above_depth,
    .unit_col, .unit_row,
    .dec_run, .ctx_addr_vld, .ctx_addr
);

cqt_depth_store i_cqt_depth_store (
    .clk, .rst_n,
    .ctb_x,
    .cu_start, .cu_x, .cu_y, .cu_log2_size,
    .cqt_done,
    .unit_col, .unit_row,
    .left_depth, .above_depth
);

endmodule

// File: hdl/cqt_defines.svh
// coding quadtree widths, sizes and the split flag context base
// shared by the quadtree walker, context select and depth store
`ifndef CQT_DEFINES_SVH
`define CQT_DEFINES_SVH

// ctb position in the picture
`define CQT_CTB_X_W         6
`define CQT_CTB_Y_W         5

// picture size in pixels
`define CQT_PIC_W_W         12
`define CQT_PIC_H_W         11

// block sizes as log2 of pixels
`define CQT_LOG2_CTB        6
`define CQT_LOG2_MIN_CU     3

`define CQT_UNITS           8    // 8x8 units per ctb side
`define CQT_MAX_CTB_COLS    64   // entries in the above-row buffer

// context memory addressing
`define CQT_CTX_ADDR_W      10
`define CQT_CTX_SPLIT_BASE  10'd2  // split_cu_flag ctx 0

`endif

// File: hdl/cqt_depth_store.sv
// quadtree depth map of the current ctb at 8x8 granularity
// keeps the last column and last row for the next ctb's neighbour lookups
`timescale 1ns/1ps
`include "cqt_defines.svh"

module cqt_depth_store (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [`CQT_CTB_X_W-1:0]                     ctb_x,
    input  logic                                        cu_start,
    input  logic [`CQT_PIC_W_W-1:0]                     cu_x,
    input  logic [`CQT_PIC_H_W-1:0]                     cu_y,
    input  logic [2:0]                                  cu_log2_size,
    input  logic                                        cqt_done,
    input  logic [`CQT_LOG2_CTB-`CQT_LOG2_MIN_CU-1:0]   unit_col,
    input  logic [`CQT_LOG2_CTB-`CQT_LOG2_MIN_CU-1:0]   unit_row,
    output cqt_syntax_pkg::cqt_depth_t                  left_depth,
    output cqt_syntax_pkg::cqt_depth_t                  above_depth
);

localparam int UW = `CQT_LOG2_CTB - `CQT_LOG2_MIN_CU;

cqt_syntax_pkg::cqt_depth_t grid      [`CQT_UNITS][`CQT_UNITS];  // [row][col]
cqt_syntax_pkg::cqt_depth_t left_buf  [`CQT_UNITS];
cqt_syntax_pkg::cqt_depth_t above_buf [`CQT_MAX_CTB_COLS][`CQT_UNITS];

logic [UW-1:0]              leaf_col;
logic [UW-1:0]              leaf_row;
logic [UW-1:0]              span_mask;
logic [2:0]                 depth_diff;
cqt_syntax_pkg::cqt_depth_t leaf_depth;

assign leaf_col = cu_x[`CQT_LOG2_CTB-1:`CQT_LOG2_MIN_CU];
assign leaf_row = cu_y[`CQT_LOG2_CTB-1:`CQT_LOG2_MIN_CU];

// units sharing the leaf's upper index bits lie inside the leaf
assign span_mask = {UW{1'b1}} << (cu_log2_size - 3'(`CQT_LOG2_MIN_CU));

assign depth_diff = 3'(`CQT_LOG2_CTB) - cu_log2_size;
assign leaf_depth = depth_diff[1:0];

always_ff @(posedge clk) begin
    if (rst_n && cu_start) begin
        for (int r = 0; r < `CQT_UNITS; r++) begin
            for (int c = 0; c < `CQT_UNITS; c++) begin
                if (((r[UW-1:0] & span_mask) == leaf_row) &&
                    ((c[UW-1:0] & span_mask) == leaf_col))
                    grid[r][c] <= leaf_depth;
            end
        end
    end
end

// right column feeds the next ctb, bottom row the ctb below
always_ff @(posedge clk) begin
    if (rst_n && cqt_done) begin
        for (int i = 0; i < `CQT_UNITS; i++) begin
            left_buf[i]         <= grid[i][`CQT_UNITS-1];
            above_buf[ctb_x][i] <= grid[`CQT_UNITS-1][i];
        end
    end
end

always_comb begin
    if (unit_col == '0)
        left_depth = left_buf[unit_row];
    else
        left_depth = grid[unit_row][unit_col - UW'(1)];
end

always_comb begin
    if (unit_row == '0)
        above_depth = above_buf[ctb_x][unit_col];
    else
        above_depth = grid[unit_row - UW'(1)][unit_col];
end

endmodule

// File: hdl/cqt_state_pkg.sv
// state encoding of the coding quadtree walker FSM
// shared with the bound checks

package cqt_state_pkg;

    typedef enum logic [2:0] {
        IDLE        = 3'd0,  // wait for cqt_start
        CALC        = 3'd1,  // classify current node
        SPLIT_FLAG  = 3'd2,  // wait for split_cu_flag bin
        FORCE_SPLIT = 3'd3,  // node crosses the picture edge
        LEAF_CU     = 3'd4,  // cu handed to the cu decoder
        NEXT        = 3'd5,  // advance or climb in z-order
        ENDING      = 3'd6   // ctb finished
    } cqt_state_t;

endpackage

// File: hdl/cqt_syntax_pkg.sv
// syntax-level types of the coding quadtree
// depth of a quadtree node and the split flag context increment

package cqt_syntax_pkg;

    // 0 is the 64x64 root, 3 is an 8x8 cu
    typedef logic [1:0] cqt_depth_t;

    // number of neighbours deeper than the current node
    typedef enum logic [1:0] {
        CTX_NONE = 2'd0,
        CTX_ONE  = 2'd1,
        CTX_BOTH = 2'd2
    } split_ctx_t;

endpackage

// File: hdl/cqt_walker.sv
// coding quadtree walker
// steps through one ctb in z-order, requests split flags and reports leaf cus
`timescale 1ns/1ps
`include "cqt_defines.svh"

module cqt_walker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cqt_start,
    input  logic [`CQT_CTB_X_W-1:0]     ctb_x,
    input  logic [`CQT_CTB_Y_W-1:0]     ctb_y,
    input  logic [`CQT_PIC_W_W-1:0]     pic_width,
    input  logic [`CQT_PIC_H_W-1:0]     pic_height,
    input  logic                        bin,
    input  logic                        bin_vld,
    input  logic                        cu_done,
    output logic [`CQT_PIC_W_W-1:0]     node_x,
    output logic [`CQT_PIC_H_W-1:0]     node_y,
    output cqt_syntax_pkg::cqt_depth_t  node_depth,
    output logic                        flag_req,
    output logic                        cu_start,
    output logic [`CQT_PIC_W_W-1:0]     cu_x,
    output logic [`CQT_PIC_H_W-1:0]     cu_y,
    output logic [2:0]                  cu_log2_size,
    output logic                        cqt_done
);

localparam int XW = `CQT_PIC_W_W + 1;
localparam int YW = `CQT_PIC_H_W + 1;

cqt_state_pkg::cqt_state_t  state, nxt_state;
cqt_syntax_pkg::cqt_depth_t depth;
logic [1:0]                 idx1, idx2, idx3;  // z-order index per depth, {y, x}
logic [1:0]                 cur_idx;
logic [2:0]                 node_log2;
logic [XW-1:0]              x_end;
logic [YW-1:0]              y_end;
logic                       outside;
logic                       crossing;

// deeper indices are kept at zero, so the position is a plain bit gather
assign node_x = {ctb_x, idx1[0], idx2[0], idx3[0], {`CQT_LOG2_MIN_CU{1'b0}}};
assign node_y = {ctb_y, idx1[1], idx2[1], idx3[1], {`CQT_LOG2_MIN_CU{1'b0}}};
assign node_depth = depth;
assign node_log2 = 3'(`CQT_LOG2_CTB) - {1'b0, depth};

assign x_end = {1'b0, node_x} + (XW'(1) << node_log2);
assign y_end = {1'b0, node_y} + (YW'(1) << node_log2);
assign outside = (node_x >= pic_width) || (node_y >= pic_height);
assign crossing = (x_end > {1'b0, pic_width}) || (y_end > {1'b0, pic_height});

always_comb begin
    case (depth)
        2'd1:    cur_idx = idx1;
        2'd2:    cur_idx = idx2;
        2'd3:    cur_idx = idx3;
        default: cur_idx = 2'd0;
    endcase
end

always_comb begin
    nxt_state = state;
    case (state)
        cqt_state_pkg::IDLE: begin
            if (cqt_start) nxt_state = cqt_state_pkg::CALC;
        end
        cqt_state_pkg::CALC: begin
            if (outside)
                nxt_state = cqt_state_pkg::NEXT;       // skipped, nothing reported
            else if (depth == 2'd3)
                nxt_state = cqt_state_pkg::LEAF_CU;    // 8x8 never splits
            else if (crossing)
                nxt_state = cqt_state_pkg::FORCE_SPLIT;
            else
                nxt_state = cqt_state_pkg::SPLIT_FLAG;
        end
        cqt_state_pkg::SPLIT_FLAG: begin
            if (bin_vld) nxt_state = bin ? cqt_state_pkg::CALC : cqt_state_pkg::LEAF_CU;
        end
        cqt_state_pkg::FORCE_SPLIT: nxt_state = cqt_state_pkg::CALC;
        cqt_state_pkg::LEAF_CU: begin
            if (cu_done) nxt_state = cqt_state_pkg::NEXT;
        end
        cqt_state_pkg::NEXT: begin
            if (depth == 2'd0)
                nxt_state = cqt_state_pkg::ENDING;
            else if (cur_idx != 2'd3)
                nxt_state = cqt_state_pkg::CALC;       // else climb and stay
        end
        cqt_state_pkg::ENDING: nxt_state = cqt_state_pkg::IDLE;
        default: nxt_state = cqt_state_pkg::IDLE;
    endcase
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state    <= cqt_state_pkg::IDLE;
        flag_req <= 1'b0;
        cu_start <= 1'b0;
        cqt_done <= 1'b0;
    end else begin
        state    <= nxt_state;
        flag_req <= (nxt_state == cqt_state_pkg::SPLIT_FLAG) &&
                    (state != cqt_state_pkg::SPLIT_FLAG);
        cu_start <= (nxt_state == cqt_state_pkg::LEAF_CU) &&
                    (state != cqt_state_pkg::LEAF_CU);
        cqt_done <= (nxt_state == cqt_state_pkg::ENDING) &&
                    (state == cqt_state_pkg::NEXT);
    end
end

always_ff @(posedge clk) begin
    if (!rst_n || (state == cqt_state_pkg::IDLE && cqt_start)) begin
        depth <= 2'd0;
        idx1  <= 2'd0;
        idx2  <= 2'd0;
        idx3  <= 2'd0;
    end else if ((state == cqt_state_pkg::SPLIT_FLAG && bin_vld && bin) ||
                 state == cqt_state_pkg::FORCE_SPLIT) begin
        depth <= depth + 2'd1;  // first child, its index is already zero
    end else if (state == cqt_state_pkg::NEXT && depth != 2'd0) begin
        if (cur_idx == 2'd3)
            depth <= depth - 2'd1;
        case (depth)
            2'd1:    idx1 <= idx1 + 2'd1;  // wraps to zero after the fourth
            2'd2:    idx2 <= idx2 + 2'd1;
            default: idx3 <= idx3 + 2'd1;
        endcase
    end
end

// leaf report holds while the cu decoder works
assign cu_x = node_x;
assign cu_y = node_y;
assign cu_log2_size = node_log2;

endmodule

// File: tb.f
+incdir+hdl
+incdir+bench
hdl/cqt_state_pkg.sv
hdl/cqt_syntax_pkg.sv
hdl/cqt_walker.sv
hdl/cqt_ctx_select.sv
hdl/cqt_depth_store.sv
hdl/cqt_decoder.sv
bench/cqt_assert.sv
bench/cqt_tb.sv
